//--- filelist.f
src/decode_pkg.sv
src/main_decoder.sv
src/imm_gen.sv
src/fetch_unit.sv
src/inst_queue.sv
src/decode_stage.sv
src/decode_top.sv
test/tb_clock.sv
test/decode_assertions.sv
test/decode_tb.sv

//--- run.sh
#!/bin/sh
# build the decode front end testbench with Verilator, run it, then check the log
verilator --binary --timing --assert --top-module decode_tb -f filelist.f -o decode_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/decode_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- src/decode_pkg.sv
package decode_pkg;

    localparam int XLEN   = 32;
    localparam int CTRL_W = 22;

    // control word bit positions, reg_write at the top
    localparam int CTRL_REG_WRITE      = 21;
    localparam int CTRL_IMM_SRC_MSB    = 20;
    localparam int CTRL_IMM_SRC_LSB    = 18;
    localparam int CTRL_ALU_SRC        = 17;
    localparam int CTRL_MEM_READ       = 16;
    localparam int CTRL_MEM_WRITE      = 15;
    localparam int CTRL_RESULT_SRC_MSB = 14;
    localparam int CTRL_RESULT_SRC_LSB = 12;
    localparam int CTRL_BRANCH         = 11;
    localparam int CTRL_ALU_OP_MSB     = 10;
    localparam int CTRL_ALU_OP_LSB     = 9;
    localparam int CTRL_JUMP           = 8;
    localparam int CTRL_C_REG_WRITE    = 7;
    localparam int CTRL_OUT_ISSUED     = 6;
    localparam int CTRL_IN_ISSUED      = 5;
    localparam int CTRL_FAST_FPU       = 4;
    localparam int CTRL_SLOW_FPU       = 3;
    localparam int CTRL_FPU_REG_WRITE  = 2;
    localparam int CTRL_WRITE_SRC      = 1;
    localparam int CTRL_S_FPU          = 0;

    localparam logic [6:0] OP_LOAD      = 7'b0000011;
    localparam logic [6:0] OP_STORE     = 7'b0100011;
    localparam logic [6:0] OP_CIN_INT   = 7'b0010100;
    localparam logic [6:0] OP_OUT       = 7'b0010001;
    localparam logic [6:0] OP_AUIPC     = 7'b0010111;
    localparam logic [6:0] OP_OP        = 7'b0110011;
    localparam logic [6:0] OP_LUI       = 7'b0110111;
    localparam logic [6:0] OP_BRANCH    = 7'b1100011;
    localparam logic [6:0] OP_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_JALR      = 7'b1100111;
    localparam logic [6:0] OP_JAL       = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM    = 7'b1110011;
    localparam logic [6:0] OP_FMADD     = 7'b1000011;
    localparam logic [6:0] OP_FMSUB     = 7'b1000111;
    localparam logic [6:0] OP_FNMSUB    = 7'b1001011;
    localparam logic [6:0] OP_FNMADD    = 7'b1001111;
    localparam logic [6:0] OP_FP        = 7'b1010011;
    localparam logic [6:0] OP_CIN_FLOAT = 7'b1010100;
    localparam logic [6:0] OP_LOAD_FP   = 7'b0000111;
    localparam logic [6:0] OP_STORE_FP  = 7'b0100111;

    localparam logic [2:0] IMM_I    = 3'b000;
    localparam logic [2:0] IMM_S    = 3'b001;
    localparam logic [2:0] IMM_B    = 3'b010;
    localparam logic [2:0] IMM_J    = 3'b011;
    localparam logic [2:0] IMM_UIMM = 3'b100;  // shift amount, zero extended
    localparam logic [2:0] IMM_U    = 3'b101;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, seen through each base format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

endpackage

//--- src/decode_stage.sv
`timescale 1ns/1ns
module decode_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          empty,
    input  logic [decode_pkg::XLEN-1:0]   head_pc,
    input  logic [decode_pkg::XLEN-1:0]   head_inst,
    input  logic                          head_fault,
    output logic                          pop,
    output logic                          dec_valid,
    input  logic                          dec_ready,
    output logic [decode_pkg::XLEN-1:0]   dec_pc,
    output logic [decode_pkg::XLEN-1:0]   dec_inst,
    output logic [decode_pkg::CTRL_W-1:0] dec_ctrl,
    output logic [decode_pkg::XLEN-1:0]   dec_imm,
    output logic                          dec_illegal
);

    decode_pkg::inst_u             inst_w;
    logic [decode_pkg::CTRL_W-1:0] raw_ctrl;
    logic                          raw_illegal;
    logic [decode_pkg::XLEN-1:0]   imm;
    logic                          bad;

    assign inst_w = head_inst;

    main_decoder main_decoder_inst (
        .opcode     (inst_w.r.opcode),
        .funct3     (inst_w.r.funct3),
        .funct7_2_6 (inst_w.r.funct7[6:2]),
        .ctrl       (raw_ctrl),
        .illegal    (raw_illegal)
    );

    imm_gen imm_gen_inst (
        .inst    (inst_w),
        .imm_src (raw_ctrl[decode_pkg::CTRL_IMM_SRC_MSB:decode_pkg::CTRL_IMM_SRC_LSB]),
        .imm     (imm)
    );

    assign bad = raw_illegal || head_fault;  // bus error counts as illegal
    assign pop = !empty && (!dec_valid || dec_ready);  // slot free or draining now

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (pop) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec_pc      <= head_pc;
            dec_inst    <= head_inst;
            dec_ctrl    <= bad ? '0 : raw_ctrl;
            dec_imm     <= imm;
            dec_illegal <= bad;
        end
    end

endmodule

//--- src/decode_top.sv
`timescale 1ns/1ns
module decode_top #(
    parameter logic [decode_pkg::XLEN-1:0] RESET_PC    = '0,
    parameter int                          QUEUE_DEPTH = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    output logic [decode_pkg::XLEN-1:0]   araddr,
    output logic [2:0]                    arprot,
    output logic                          arvalid,
    input  logic                          arready,
    input  logic [decode_pkg::XLEN-1:0]   rdata,
    input  logic [1:0]                    rresp,
    input  logic                          rvalid,
    output logic                          rready,
    output logic                          dec_valid,
    input  logic                          dec_ready,
    output logic [decode_pkg::XLEN-1:0]   dec_pc,
    output logic [decode_pkg::XLEN-1:0]   dec_inst,
    output logic [decode_pkg::CTRL_W-1:0] dec_ctrl,
    output logic [decode_pkg::XLEN-1:0]   dec_imm,
    output logic                          dec_illegal
);

    logic                        push;
    logic [decode_pkg::XLEN-1:0] push_pc;
    logic [decode_pkg::XLEN-1:0] push_inst;
    logic                        push_fault;
    logic [$clog2(QUEUE_DEPTH):0] free_slots;
    logic                        pop;
    logic                        empty;
    logic [decode_pkg::XLEN-1:0] head_pc;
    logic [decode_pkg::XLEN-1:0] head_inst;
    logic                        head_fault;

    fetch_unit #(
        .RESET_PC (RESET_PC),
        .DEPTH    (QUEUE_DEPTH)
    ) fetch_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .araddr     (araddr),
        .arprot     (arprot),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .push       (push),
        .push_pc    (push_pc),
        .push_inst  (push_inst),
        .push_fault (push_fault),
        .free_slots (free_slots)
    );

    inst_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) inst_queue_inst (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_pc    (push_pc),
        .push_inst  (push_inst),
        .push_fault (push_fault),
        .pop        (pop),
        .empty      (empty),
        .head_pc    (head_pc),
        .head_inst  (head_inst),
        .head_fault (head_fault),
        .free_slots (free_slots)
    );

    decode_stage decode_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .empty       (empty),
        .head_pc     (head_pc),
        .head_inst   (head_inst),
        .head_fault  (head_fault),
        .pop         (pop),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_pc      (dec_pc),
        .dec_inst    (dec_inst),
        .dec_ctrl    (dec_ctrl),
        .dec_imm     (dec_imm),
        .dec_illegal (dec_illegal)
    );

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ns
module fetch_unit #(
    parameter logic [decode_pkg::XLEN-1:0] RESET_PC = '0,
    parameter int                          DEPTH    = 8
) (
    input  logic                        clk,
    input  logic                        rst,
    output logic [decode_pkg::XLEN-1:0] araddr,
    output logic [2:0]                  arprot,
    output logic                        arvalid,
    input  logic                        arready,
    input  logic [decode_pkg::XLEN-1:0] rdata,
    input  logic [1:0]                  rresp,
    input  logic                        rvalid,
    output logic                        rready,
    output logic                        push,
    output logic [decode_pkg::XLEN-1:0] push_pc,
    output logic [decode_pkg::XLEN-1:0] push_inst,
    output logic                        push_fault,
    input  logic [$clog2(DEPTH):0]      free_slots
);

    localparam logic ST_AR = 1'b0;
    localparam logic ST_R  = 1'b1;

    logic                        state;
    logic [decode_pkg::XLEN-1:0] pc;

    assign araddr     = pc;  // held with arvalid until accepted
    assign arprot     = 3'b100;  // instruction, secure, unprivileged
    assign rready     = (state == ST_R);
    assign push       = rready && rvalid;
    assign push_pc    = pc;
    assign push_inst  = rdata;
    assign push_fault = (rresp != 2'b00);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_AR;
            arvalid <= 1'b0;
            pc      <= RESET_PC;
        end else begin
            case (state)
                ST_AR: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        state   <= ST_R;
                    end else if (!arvalid && free_slots != '0) begin
                        arvalid <= 1'b1;
                    end
                end
                ST_R: begin
                    if (rvalid) begin
                        state   <= ST_AR;
                        pc      <= pc + 32'd4;
                        arvalid <= (free_slots > 1);  // the reply takes one slot
                    end
                end
                default: state <= ST_AR;
            endcase
        end
    end

endmodule

//--- src/imm_gen.sv
`timescale 1ns/1ns
module imm_gen (
    input  decode_pkg::inst_u             inst,
    input  logic [2:0]                    imm_src,
    output logic [decode_pkg::XLEN-1:0]   imm
);

    always_comb begin
        case (imm_src)
            decode_pkg::IMM_I:
                imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
            decode_pkg::IMM_S:
                imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            decode_pkg::IMM_B:
                imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};  // halfword aligned
            decode_pkg::IMM_J:
                imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            decode_pkg::IMM_UIMM:
                imm = {27'b0, inst.i.imm_11_0[4:0]};  // shamt only
            decode_pkg::IMM_U:
                imm = {inst.u.imm_31_12, 12'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

//--- src/inst_queue.sv
`timescale 1ns/1ns
module inst_queue #(
    parameter int DEPTH = 8  // power of two
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic [decode_pkg::XLEN-1:0] push_pc,
    input  logic [decode_pkg::XLEN-1:0] push_inst,
    input  logic                        push_fault,
    input  logic                        pop,
    output logic                        empty,
    output logic [decode_pkg::XLEN-1:0] head_pc,
    output logic [decode_pkg::XLEN-1:0] head_inst,
    output logic                        head_fault,
    output logic [$clog2(DEPTH):0]      free_slots
);

    localparam int PTR_W = $clog2(DEPTH);

    logic [decode_pkg::XLEN-1:0] pc_mem   [DEPTH];
    logic [decode_pkg::XLEN-1:0] inst_mem [DEPTH];
    logic [DEPTH-1:0]            fault_mem;
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [PTR_W:0]              count;
    logic                        do_push;
    logic                        do_pop;

    assign empty      = (count == '0);
    assign do_pop     = pop && !empty;
    assign do_push    = push && (count != (PTR_W+1)'(DEPTH) || do_pop);  // full unless draining
    assign free_slots = (PTR_W+1)'(DEPTH) - count;
    assign head_pc    = pc_mem[rd_ptr];
    assign head_inst  = inst_mem[rd_ptr];
    assign head_fault = fault_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]    <= push_pc;
            inst_mem[wr_ptr]  <= push_inst;
            fault_mem[wr_ptr] <= push_fault;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

endmodule

//--- src/main_decoder.sv
`timescale 1ns/1ns
module main_decoder (
    input  logic [6:0]                    opcode,
    input  logic [2:0]                    funct3,
    input  logic [4:0]                    funct7_2_6,
    output logic [decode_pkg::CTRL_W-1:0] ctrl,
    output logic                          illegal
);

    // field order: reg_write imm_src alu_src mem_read mem_write result_src
    // branch alu_op jump c_reg_write out in fast slow fpu_reg_write write_src s_fpu
    always_comb begin
        ctrl    = '0;  // unknown rows decode to nothing
        illegal = 1'b0;
        case (opcode)
            decode_pkg::OP_LOAD:      ctrl = 22'b1_000_1_1_0_001_0_00_0_0_0_0_0_0_0_0_0;  // lw
            decode_pkg::OP_STORE:     ctrl = 22'b0_001_1_0_1_000_0_00_0_0_0_0_0_0_0_0_0;  // sw
            decode_pkg::OP_CIN_INT:   ctrl = 22'b1_000_0_0_0_111_0_00_0_0_0_1_0_0_0_0_0;
            decode_pkg::OP_OUT:       ctrl = 22'b0_000_0_0_0_000_0_00_0_0_1_0_0_0_0_0_0;
            decode_pkg::OP_AUIPC:     ctrl = 22'b1_101_1_0_0_000_0_11_0_0_0_0_0_0_0_0_0;
            decode_pkg::OP_OP:        ctrl = 22'b1_000_0_0_0_000_0_10_0_0_0_0_0_0_0_0_0;  // r-type
            decode_pkg::OP_LUI:       ctrl = 22'b1_101_0_0_0_100_0_00_0_0_0_0_0_0_0_0_0;
            decode_pkg::OP_BRANCH:    ctrl = 22'b0_010_0_0_0_000_1_01_0_0_0_0_0_0_0_0_0;
            decode_pkg::OP_OP_IMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    ctrl = 22'b1_100_1_0_0_000_0_10_0_0_0_0_0_0_0_0_0;  // shifts take uimm
                end else begin
                    ctrl = 22'b1_000_1_0_0_000_0_10_0_0_0_0_0_0_0_0_0;
                end
            end
            decode_pkg::OP_JALR:      ctrl = 22'b1_000_1_0_0_010_0_10_1_0_0_0_0_0_0_0_0;
            decode_pkg::OP_JAL:       ctrl = 22'b1_011_1_0_0_010_0_11_1_0_0_0_0_0_0_0_0;
            decode_pkg::OP_SYSTEM:    ctrl = 22'b1_000_0_0_0_011_0_00_0_1_0_0_0_0_0_0_0;  // csrrw
            decode_pkg::OP_FMADD,
            decode_pkg::OP_FMSUB,
            decode_pkg::OP_FNMSUB,
            decode_pkg::OP_FNMADD:    ctrl = 22'b0_000_0_0_0_110_0_00_0_0_0_0_0_1_1_0_1;  // fused, slow
            decode_pkg::OP_FP: begin
                casez (funct7_2_6)
                    5'b0000?,                                                   // fadd, fsub
                    5'b00010,                                                   // fmul
                    5'b00100,                                                   // sign inject
                    5'b00101: ctrl = 22'b0_000_0_0_0_110_0_00_0_0_0_0_1_0_1_0_1;  // fmin, fmax
                    5'b00011,                                                   // fdiv
                    5'b01011: ctrl = 22'b0_000_0_0_0_110_0_00_0_0_0_0_0_1_1_0_1;  // fsqrt
                    5'b10100,                                                   // compares
                    5'b11000: ctrl = 22'b1_000_0_0_0_110_0_00_0_0_0_0_1_0_0_0_1;  // fcvt.w.s
                    5'b11100: begin
                        case (funct3)
                            3'b001:  ctrl = 22'b1_000_0_0_0_110_0_00_0_0_0_0_1_0_0_0_1;  // fclass
                            3'b000:  ctrl = 22'b1_000_0_0_0_101_0_00_0_0_0_0_0_0_0_0_1;  // fmv.x.w
                            default: illegal = 1'b1;
                        endcase
                    end
                    5'b11010: ctrl = 22'b0_000_0_0_0_110_0_00_0_0_0_0_1_0_1_0_0;  // fcvt.s.w
                    5'b11110: ctrl = 22'b0_000_0_0_0_011_0_00_0_0_0_0_0_0_1_0_0;  // fmv.w.x
                    default:  illegal = 1'b1;
                endcase
            end
            decode_pkg::OP_CIN_FLOAT: ctrl = 22'b0_000_0_0_0_111_0_00_0_0_0_1_0_0_1_0_0;
            decode_pkg::OP_LOAD_FP:   ctrl = 22'b0_000_1_1_0_001_0_00_0_0_0_0_0_0_1_0_0;  // flw
            decode_pkg::OP_STORE_FP:  ctrl = 22'b0_001_1_0_1_110_0_00_0_0_0_0_0_0_0_1_1;  // fsw
            default:                  illegal = 1'b1;
        endcase
    end

endmodule

//--- test/decode_assertions.sv
`timescale 1ns/1ns
module decode_assertions (
    input logic                          clk,
    input logic                          rst,
    input logic                          arvalid,
    input logic                          arready,
    input logic [decode_pkg::XLEN-1:0]   araddr,
    input logic                          rvalid,
    input logic                          rready,
    input logic [decode_pkg::XLEN-1:0]   rdata,
    input logic [1:0]                    rresp,
    input logic                          dec_valid,
    input logic                          dec_ready,
    input logic [decode_pkg::XLEN-1:0]   dec_pc,
    input logic [decode_pkg::CTRL_W-1:0] dec_ctrl,
    input logic [decode_pkg::XLEN-1:0]   dec_imm,
    input logic                          dec_illegal
);

    int fail_count = 0;  // read by the testbench top

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("AR request dropped or address changed before acceptance");
            fail_count++;
        end

    // one read in flight, so a reply is taken the cycle it shows up
    r_taken: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rready)
        else begin
            $error("R reply arrived while the fetch unit was not ready for it");
            fail_count++;
        end

    dec_hold: assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_pc) && $stable(dec_ctrl)
                                    && $stable(dec_imm) && $stable(dec_illegal))
        else begin
            $error("decoded output changed while stalled");
            fail_count++;
        end

    mem_excl: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> !(dec_ctrl[decode_pkg::CTRL_MEM_READ]
                        && dec_ctrl[decode_pkg::CTRL_MEM_WRITE]))
        else begin
            $error("mem_read and mem_write both set");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        rst |=> !dec_valid && !arvalid)
        else begin
            $error("dec_valid or arvalid high during reset");
            fail_count++;
        end

endmodule

//--- test/decode_golden.txt
// columns in hex: fault_inst_ctrl_imm_illegal, ctrl holds 22 bits in 6 digits
// fault 1 makes the memory answer that word with SLVERR
0_00812083_231000_00000008_0 // lw x1,8(x2)
0_FE312E23_068000_FFFFFFFC_0 // sw x3,-4(x2)
0_12345297_360600_12345000_0 // auipc x5
0_ABCDE337_344000_ABCDE000_0 // lui x6
0_002083B3_200400_00000002_0 // add x7,x1,x2
0_4070D413_320400_00000007_0 // srai x8,x1,7
0_80008493_220400_FFFFF800_0 // addi x9,x1,-2048
0_FE208CE3_080A00_FFFFFFF8_0 // beq x1,x2,-8
0_001000EF_2E2700_00000800_0 // jal x1,0x800
0_00C08067_222500_0000000C_0 // jalr x0,12(x1)
0_300091F3_203080_00000300_0 // csrrw x3,0x300,x1
1_002083B3_000000_00000002_1 // add with bus error
0_203100C3_00600D_00000203_0 // fmadd.s
0_003100D3_006015_00000003_0 // fadd.s
0_183100D3_00600D_00000183_0 // fdiv.s
0_580100D3_00600D_00000580_0 // fsqrt.s
0_A03120D3_206011_FFFFFA03_0 // feq.s
0_E00110D3_206011_FFFFFE00_0 // fclass.s
0_E00100D3_205001_FFFFFE00_0 // fmv.x.w
0_D00100D3_006014_FFFFFD00_0 // fcvt.s.w
0_00412087_031004_00000004_0 // flw f1,4(x2)
0_00312827_06E003_00000010_0 // fsw f3,16(x2)
0_00000094_207020_00000000_0 // cin_int
0_000000D4_007024_00000000_0 // cin_float
0_00008011_000040_00000000_0 // out
0_1230007F_000000_00000123_1 // unknown opcode
0_F80100D3_000000_FFFFFF80_1 // unknown fp funct7

//--- test/decode_tb.sv
`timescale 1ns/1ns
module decode_tb;

    localparam logic [decode_pkg::XLEN-1:0] RESET_PC = 32'h0000_1000;
    localparam int QUEUE_DEPTH    = 4;
    localparam int N_ENTRIES      = 27;  // lines in the golden file
    localparam int TIMEOUT_CYCLES = N_ENTRIES * 40 + 200;

    logic                          clk;
    logic                          rst       = 1'b1;
    logic [decode_pkg::XLEN-1:0]   araddr;
    logic [2:0]                    arprot;
    logic                          arvalid;
    logic                          arready   = 1'b0;
    logic [decode_pkg::XLEN-1:0]   rdata     = '0;
    logic [1:0]                    rresp     = 2'b00;
    logic                          rvalid    = 1'b0;
    logic                          rready;
    logic                          dec_valid;
    logic                          dec_ready = 1'b0;
    logic [decode_pkg::XLEN-1:0]   dec_pc;
    logic [decode_pkg::XLEN-1:0]   dec_inst;
    logic [decode_pkg::CTRL_W-1:0] dec_ctrl;
    logic [decode_pkg::XLEN-1:0]   dec_imm;
    logic                          dec_illegal;

    // {fault, inst, ctrl, imm, illegal}, see the golden file
    logic [95:0]                   golden [32];
    logic [95:0]                   exp_entry;
    logic                          rd_pending = 1'b0;
    logic [decode_pkg::XLEN-1:0]   rd_addr    = '0;
    int                            rd_delay   = 0;
    logic                          seen_ar    = 1'b0;
    int                            received   = 0;
    int                            cycles     = 0;
    int                            mismatches = 0;
    int                            timeouts   = 0;
    int                            assert_fails;

    tb_clock #(.PERIOD(100)) tb_clock_inst (.clk(clk));

    decode_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) decode_top_inst (
        .clk         (clk),
        .rst         (rst),
        .araddr      (araddr),
        .arprot      (arprot),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_pc      (dec_pc),
        .dec_inst    (dec_inst),
        .dec_ctrl    (dec_ctrl),
        .dec_imm     (dec_imm),
        .dec_illegal (dec_illegal)
    );

    bind decode_top decode_assertions decode_assertions_inst (
        .clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_pc(dec_pc),
        .dec_ctrl(dec_ctrl), .dec_imm(dec_imm), .dec_illegal(dec_illegal)
    );

    task automatic check_ctrl(input string what, input logic [decode_pkg::CTRL_W-1:0] got,
                              input logic [decode_pkg::CTRL_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s ctrl got %h expected %h (fast %b slow %b)", $time,
                     what, got, exp, got[decode_pkg::CTRL_FAST_FPU],
                     got[decode_pkg::CTRL_SLOW_FPU]);
            mismatches++;
        end
    endtask

    task automatic check_imm(input string what, input logic [decode_pkg::XLEN-1:0] got,
                             input logic [decode_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s imm got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_pc(input string what, input logic [decode_pkg::XLEN-1:0] got,
                            input logic [decode_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_inst(input string what, input logic [decode_pkg::XLEN-1:0] got,
                              input logic [decode_pkg::XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s inst got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_illegal(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s illegal got %b expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    function automatic logic [decode_pkg::XLEN-1:0] word_at(input logic [31:0] addr);
        logic [31:0] slot;
        slot = (addr - RESET_PC) >> 2;
        if (slot < 32'(N_ENTRIES)) return golden[slot[4:0]][91:60];
        return 32'h0000_0013;  // nop past the end
    endfunction

    function automatic logic [1:0] resp_at(input logic [31:0] addr);
        logic [31:0] slot;
        slot = (addr - RESET_PC) >> 2;
        if (slot < 32'(N_ENTRIES) && golden[slot[4:0]][92]) return 2'b10;  // SLVERR
        return 2'b00;
    endfunction

    // AXI4-Lite read slave with random AR and R delays
    always @(posedge clk) begin
        if (rst) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rd_pending <= 1'b0;
        end else begin
            arready <= ($urandom_range(0, 2) != 0);
            if (arvalid && arready) begin
                rd_pending <= 1'b1;
                rd_addr    <= araddr;
                rd_delay   <= $urandom_range(0, 3);
            end
            if (rd_pending && !rvalid) begin
                if (rd_delay == 0) begin
                    rvalid     <= 1'b1;
                    rdata      <= word_at(rd_addr);
                    rresp      <= resp_at(rd_addr);
                    rd_pending <= 1'b0;
                end else begin
                    rd_delay <= rd_delay - 1;
                end
            end
            if (rvalid && rready) rvalid <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            dec_ready <= 1'b0;
        end else if (received >= 8 && received < 16) begin
            dec_ready <= ($urandom_range(0, 4) == 0);  // long stalls fill the queue
        end else begin
            dec_ready <= ($urandom_range(0, 1) == 1);
        end
        if (!rst) cycles <= cycles + 1;
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            check_level("arvalid during reset", arvalid, 1'b0);
            check_level("dec_valid during reset", dec_valid, 1'b0);
        end else begin
            if (arvalid && !seen_ar) begin
                check_pc("first araddr", araddr, RESET_PC);
                seen_ar <= 1'b1;
            end
            if (arvalid) begin
                check_level("arprot instruction bit", arprot[2], 1'b1);
            end
            if (dec_valid && dec_ready && received < N_ENTRIES) begin
                exp_entry = golden[received[4:0]];
                check_pc($sformatf("entry %0d pc", received), dec_pc,
                         RESET_PC + (32'(received) << 2));
                check_inst($sformatf("entry %0d", received), dec_inst, exp_entry[91:60]);
                check_ctrl($sformatf("entry %0d", received), dec_ctrl, exp_entry[57:36]);
                check_imm($sformatf("entry %0d", received), dec_imm, exp_entry[35:4]);
                check_illegal($sformatf("entry %0d", received), dec_illegal, exp_entry[0]);
                received <= received + 1;
            end
        end
    end

    initial begin
        void'($urandom(70));
        $readmemh("test/decode_golden.txt", golden);
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        while (received < N_ENTRIES && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (received < N_ENTRIES) begin
            $display("timeout: only %0d of %0d decoded instructions arrived in %0d cycles",
                     received, N_ENTRIES, TIMEOUT_CYCLES);
            timeouts++;
        end
        repeat (2) @(posedge clk);
        assert_fails = decode_top_inst.decode_assertions_inst.fail_count;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, assert_fails);
        if (mismatches == 0 && timeouts == 0 && assert_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ns
module tb_clock #(
    parameter int PERIOD = 100  // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule
